//--- hdl/snd_pkg.sv
/*
 shared widths, sample types and constants of the sound mixing path
 used by scoped name in the voice, fifo, mixer and pop interface
*/
package snd_pkg;

    // widths
    localparam int ROM_ADDR_W = 18;          // sample rom byte address
    localparam int PCM_W      = 12;          // decoded pcm sample
    localparam int AUDIO_W    = 16;          // fm input and mixed output

    // sample fifo
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);   // pointer width

    // decoder
    localparam int DELTA_SHIFT = 4;          // nibble to pcm step scaling

    // fixed point gain, 4 integer bits and 4 fraction bits
    localparam int GAIN_FRAC = 4;

    typedef logic [ROM_ADDR_W-1:0]     rom_addr_t;
    typedef logic [7:0]                rom_byte_t;     // two deltas, high nibble first
    typedef logic signed [PCM_W-1:0]   pcm_sample_t;
    typedef logic signed [AUDIO_W-1:0] audio_t;
    typedef logic [7:0]                gain_t;         // unsigned 4.4

    // 1.0 in 4.4, base of both channel gains
    localparam gain_t GAIN_UNITY = 8'h10;

endpackage

//--- hdl/pcm_stream_if.sv
/*
 pop link from the sample fifo to the mixer
 four-phase req/ack, the fifo answers every req, zero data on underrun
*/
interface pcm_stream_if;

    logic                 req;        // mixer wants one sample
    logic                 ack;        // fifo answer, one cycle after req
    snd_pkg::pcm_sample_t data;       // valid while ack is high
    logic                 underrun;   // fifo was empty, data is zero

    modport fifo (
        input  req,
        output ack,
        output data,
        output underrun
    );

    modport mixer (
        output req,
        input  ack,
        input  data,
        input  underrun
    );

endinterface

//--- hdl/adpcm_voice.sv
/*
 single pcm voice, programmed by the cpu with a start address and a byte count
 fetches rom bytes over a four-phase port and pushes two decoded samples per byte
*/
module adpcm_voice (
    input  logic                 CLK96,
    input  logic                 rst_n,
    // cpu registers, single cycle writes
    input  logic                 cpu_we,
    input  logic [1:0]           cpu_addr,
    input  logic [7:0]           cpu_din,
    output logic                 cpu_busy,
    // sample rom
    output logic                 rom_req,
    input  logic                 rom_ack,
    output snd_pkg::rom_addr_t   rom_addr,
    input  snd_pkg::rom_byte_t   rom_data,
    // push into sample fifo
    output logic                 push_req,
    input  logic                 push_ack,
    output snd_pkg::pcm_sample_t push_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,      // waiting on the rom
        ST_PUSH_HI,    // first sample of the byte
        ST_PUSH_LO     // second sample of the byte
    } state_t;

    state_t               state;
    snd_pkg::rom_addr_t   start_addr;    // cpu programmed
    logic [7:0]           bytes_left;
    snd_pkg::pcm_sample_t acc;           // decoder output, also the push payload
    logic [3:0]           lo_nib;        // second delta of the current byte
    logic                 start;
    logic                 fetch_done;
    logic                 push_done;

    // one decode step: signed nibble scaled up, added, clamped to pcm range
    function automatic snd_pkg::pcm_sample_t decode_step(
        input snd_pkg::pcm_sample_t prev,
        input logic [3:0]           nib
    );
        logic signed [snd_pkg::PCM_W:0] delta;
        logic signed [snd_pkg::PCM_W:0] sum;
        delta = $signed(nib) <<< snd_pkg::DELTA_SHIFT;   // sign extends first
        sum   = prev + delta;
        if (sum[snd_pkg::PCM_W] != sum[snd_pkg::PCM_W-1]) begin
            // out of 12-bit range, pick the rail by sign
            decode_step = sum[snd_pkg::PCM_W] ? {1'b1, {(snd_pkg::PCM_W-1){1'b0}}}
                                              : {1'b0, {(snd_pkg::PCM_W-1){1'b1}}};
        end else begin
            decode_step = sum[snd_pkg::PCM_W-1:0];
        end
    endfunction

    // count of zero plays nothing
    assign start      = cpu_we && cpu_addr == 2'd3 && state == ST_IDLE && cpu_din != 8'd0;
    assign fetch_done = state == ST_FETCH && rom_req && rom_ack;
    // push states are entered with req high, so both low means the handshake closed
    assign push_done  = (state == ST_PUSH_HI || state == ST_PUSH_LO) && !push_req && !push_ack;

    assign cpu_busy  = state != ST_IDLE;
    assign push_data = acc;    // acc only moves while push_req is low

    always_ff @(posedge CLK96 or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            start_addr <= '0;
            rom_addr   <= '0;
            bytes_left <= '0;
            acc        <= '0;
            rom_req    <= 1'b0;
            push_req   <= 1'b0;
        end else begin
            if (cpu_we) begin
                case (cpu_addr)
                    2'd0:    start_addr[7:0]   <= cpu_din;
                    2'd1:    start_addr[15:8]  <= cpu_din;
                    2'd2:    start_addr[17:16] <= cpu_din[1:0];
                    default: ;                 // count, handled by start
                endcase
            end

            case (state)
                ST_IDLE: begin
                    if (start) begin
                        rom_addr   <= start_addr;
                        bytes_left <= cpu_din;
                        acc        <= '0;          // fresh decode per play
                        state      <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if (fetch_done) begin
                        rom_req  <= 1'b0;
                        acc      <= decode_step(acc, rom_data[7:4]);   // high nibble first
                        push_req <= 1'b1;
                        state    <= ST_PUSH_HI;
                    end else if (!rom_req && !rom_ack) begin
                        rom_req <= 1'b1;           // previous ack gone, ask again
                    end
                end
                ST_PUSH_HI: begin
                    if (push_req && push_ack) begin
                        push_req <= 1'b0;
                    end else if (push_done) begin
                        acc      <= decode_step(acc, lo_nib);
                        push_req <= 1'b1;
                        state    <= ST_PUSH_LO;
                    end
                end
                ST_PUSH_LO: begin
                    if (push_req && push_ack) begin
                        push_req <= 1'b0;
                    end else if (push_done) begin
                        if (bytes_left == 8'd1) begin
                            state <= ST_IDLE;      // busy drops here
                        end else begin
                            bytes_left <= bytes_left - 8'd1;
                            rom_addr   <= rom_addr + 1'b1;
                            state      <= ST_FETCH;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK96) begin
        if (fetch_done) lo_nib <= rom_data[3:0];   // kept for the second push
    end

    // rom sees one address for the whole request
    a_rom_addr_stable: assert property (@(posedge CLK96) disable iff (!rst_n)
        rom_req |=> !rom_req || $stable(rom_addr))
        else $error("rom_addr moved during a rom request");

    // four-phase push, req holds until the fifo answers
    a_push_hold: assert property (@(posedge CLK96) disable iff (!rst_n)
        push_req && !push_ack |=> push_req)
        else $error("push_req dropped before push_ack");

endmodule

//--- hdl/sample_fifo.sv
/*
 eight entry pcm sample buffer between the voice and the mixer
 four-phase push side with back-pressure when full, pop side zero fills on empty
*/
module sample_fifo (
    input  logic                 CLK96,
    input  logic                 rst_n,
    input  logic                 push_req,
    input  snd_pkg::pcm_sample_t push_data,
    output logic                 push_ack,
    pcm_stream_if.fifo           pop
);

    snd_pkg::pcm_sample_t            mem [snd_pkg::FIFO_DEPTH];
    logic [snd_pkg::FIFO_AW-1:0]     wr_ptr;
    logic [snd_pkg::FIFO_AW-1:0]     rd_ptr;
    logic [snd_pkg::FIFO_AW:0]       count;     // one bit wider than the pointers
    logic                            full;
    logic                            empty;
    logic                            do_push;
    logic                            do_pop;
    logic                            pop_take;  // pop that actually removes an entry

    assign full     = count[snd_pkg::FIFO_AW];  // only set at exactly FIFO_DEPTH
    assign empty    = count == '0;
    assign do_push  = push_req && !push_ack && !full;   // full holds the ack back
    assign do_pop   = pop.req && !pop.ack;
    assign pop_take = do_pop && !empty;

    always_ff @(posedge CLK96 or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            push_ack     <= 1'b0;
            pop.ack      <= 1'b0;
            pop.underrun <= 1'b0;
        end else begin
            // push side
            if (do_push) begin
                push_ack <= 1'b1;
                wr_ptr   <= wr_ptr + 1'b1;      // wraps, depth is a power of two
            end else if (!push_req) begin
                push_ack <= 1'b0;
            end

            // pop side, always answered
            if (do_pop) begin
                pop.ack      <= 1'b1;
                pop.underrun <= empty;
                if (!empty) rd_ptr <= rd_ptr + 1'b1;
            end else if (!pop.req) begin
                pop.ack <= 1'b0;
            end

            case ({do_push, pop_take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                       // none, or one in and one out
            endcase
        end
    end

    always_ff @(posedge CLK96) begin
        if (do_push) mem[wr_ptr] <= push_data;
        if (do_pop)  pop.data    <= empty ? '0 : mem[rd_ptr];   // silence on underrun
    end

    a_count_bound: assert property (@(posedge CLK96) disable iff (!rst_n)
        count <= snd_pkg::FIFO_DEPTH)
        else $error("fifo count above depth");

    // ack may linger one cycle after the mixer lets go of req
    a_pop_ack_window: assert property (@(posedge CLK96) disable iff (!rst_n)
        pop.ack |-> pop.req || $past(pop.req))
        else $error("pop ack without a request");

endmodule

//--- hdl/sound_mixer.sv
/*
 mixes the fm sample with one popped pcm sample at each fm strobe
 two stage datapath, gains then sum and saturate, mix_valid four cycles after the strobe
*/
module sound_mixer (
    input  logic            CLK96,
    input  logic            rst_n,
    input  logic            fm_sample,    // one cycle strobe
    input  snd_pkg::audio_t fm_in,
    input  logic            fm_en,
    input  logic            pcm_en,
    input  logic [1:0]      fx_level,
    output snd_pkg::audio_t mix_out,
    output logic            mix_valid,
    output logic            peak,         // sticky until reset
    pcm_stream_if.mixer     pop
);

    snd_pkg::audio_t                 fm_lat;        // fm held from the strobe
    snd_pkg::gain_t                  fm_gain;
    snd_pkg::gain_t                  pcm_gain;
    snd_pkg::pcm_sample_t            pcm_src;
    logic signed [snd_pkg::AUDIO_W+8:0] fm_prod_q;  // 16 x 9 signed
    logic signed [snd_pkg::PCM_W+8:0]   pcm_prod_q; // 12 x 9 signed
    logic signed [snd_pkg::AUDIO_W+9:0] sum;
    logic signed [snd_pkg::AUDIO_W+9-snd_pkg::GAIN_FRAC:0] scaled;
    logic                            s1_go;         // ack seen, run stage 1
    logic                            s1_valid;
    logic                            sat;

    assign fm_gain  = fm_en ? snd_pkg::GAIN_UNITY : '0;
    // pcm louder by fx_level eighths
    assign pcm_gain = pcm_en ? snd_pkg::GAIN_UNITY + {5'd0, fx_level, 1'b0} : '0;
    assign pcm_src  = pop.underrun ? '0 : pop.data;
    assign s1_go    = pop.req && pop.ack;

    // stage 2 combinational part
    assign sum    = fm_prod_q + pcm_prod_q;
    assign scaled = sum[snd_pkg::AUDIO_W+9:snd_pkg::GAIN_FRAC];   // drop 4.4 fraction
    // bits above the output sign must all match it
    assign sat    = !(&scaled[$left(scaled):snd_pkg::AUDIO_W-1])
                    && (|scaled[$left(scaled):snd_pkg::AUDIO_W-1]);

    always_ff @(posedge CLK96 or negedge rst_n) begin
        if (!rst_n) begin
            pop.req   <= 1'b0;
            s1_valid  <= 1'b0;
            mix_valid <= 1'b0;
            mix_out   <= '0;
            peak      <= 1'b0;
        end else begin
            if (s1_go) begin
                pop.req <= 1'b0;             // fifo drops ack next
            end else if (fm_sample) begin
                pop.req <= 1'b1;             // one pop per strobe
            end

            s1_valid  <= s1_go;
            mix_valid <= s1_valid;           // single cycle pulse

            if (s1_valid) begin
                if (sat) begin
                    mix_out <= scaled[$left(scaled)]
                               ? {1'b1, {(snd_pkg::AUDIO_W-1){1'b0}}}
                               : {1'b0, {(snd_pkg::AUDIO_W-1){1'b1}}};
                    peak    <= 1'b1;
                end else begin
                    mix_out <= scaled[snd_pkg::AUDIO_W-1:0];
                end
            end
        end
    end

    // datapath registers
    always_ff @(posedge CLK96) begin
        if (fm_sample) fm_lat <= fm_in;
        if (s1_go) begin
            // gains are unsigned, zero extend before the signed multiply
            fm_prod_q  <= fm_lat * $signed({1'b0, fm_gain});
            pcm_prod_q <= pcm_src * $signed({1'b0, pcm_gain});
        end
    end

    a_valid_pulse: assert property (@(posedge CLK96) disable iff (!rst_n)
        mix_valid |=> !mix_valid)
        else $error("mix_valid high two cycles in a row");

endmodule

//--- hdl/sound_board.sv
/*
 top of the sound mixing path, voice into fifo into mixer
 all outside signals are plain ports, fm samples come from outside
*/
module sound_board (
    input  logic               CLK96,
    input  logic               rst_n,
    // cpu register port
    input  logic               cpu_we,
    input  logic [1:0]         cpu_addr,
    input  logic [7:0]         cpu_din,
    output logic               cpu_busy,
    // sample rom, four-phase
    output logic               rom_req,
    input  logic               rom_ack,
    output snd_pkg::rom_addr_t rom_addr,
    input  snd_pkg::rom_byte_t rom_data,
    // fm and mix control
    input  logic               fm_sample,
    input  snd_pkg::audio_t    fm_in,
    input  logic               fm_en,
    input  logic               pcm_en,
    input  logic [1:0]         fx_level,
    // mixed output
    output snd_pkg::audio_t    mix_out,
    output logic               mix_valid,
    output logic               peak
);

    logic                 push_req;    // voice to fifo
    logic                 push_ack;
    snd_pkg::pcm_sample_t push_data;

    pcm_stream_if pop_if ();           // fifo to mixer

    adpcm_voice u_voice (
        .CLK96     ( CLK96     ),
        .rst_n     ( rst_n     ),
        .cpu_we    ( cpu_we    ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_din   ( cpu_din   ),
        .cpu_busy  ( cpu_busy  ),
        .rom_req   ( rom_req   ),
        .rom_ack   ( rom_ack   ),
        .rom_addr  ( rom_addr  ),
        .rom_data  ( rom_data  ),
        .push_req  ( push_req  ),
        .push_ack  ( push_ack  ),
        .push_data ( push_data )
    );

    sample_fifo u_fifo (
        .CLK96     ( CLK96     ),
        .rst_n     ( rst_n     ),
        .push_req  ( push_req  ),
        .push_data ( push_data ),
        .push_ack  ( push_ack  ),
        .pop       ( pop_if    )
    );

    sound_mixer u_mixer (
        .CLK96     ( CLK96     ),
        .rst_n     ( rst_n     ),
        .fm_sample ( fm_sample ),
        .fm_in     ( fm_in     ),
        .fm_en     ( fm_en     ),
        .pcm_en    ( pcm_en    ),
        .fx_level  ( fx_level  ),
        .mix_out   ( mix_out   ),
        .mix_valid ( mix_valid ),
        .peak      ( peak      ),
        .pop       ( pop_if    )
    );

endmodule

//--- verif/tb_sound_board.sv
/*
 directed testbench for the sound board, sample rom modelled with random ack delay
 every mix is compared with a reference decoder and mixer built from the decode and gain rules
*/
module tb_sound_board;

    logic               CLK96 = 1'b0;
    logic               rst_n;
    logic               cpu_we;
    logic [1:0]         cpu_addr;
    logic [7:0]         cpu_din;
    logic               cpu_busy;
    logic               rom_req;
    logic               rom_ack;
    snd_pkg::rom_addr_t rom_addr;
    snd_pkg::rom_byte_t rom_data;
    logic               fm_sample;
    snd_pkg::audio_t    fm_in;
    logic               fm_en;
    logic               pcm_en;
    logic [1:0]         fx_level;
    snd_pkg::audio_t    mix_out;
    logic               mix_valid;
    logic               peak;

    integer             seed = 32'h57e35559;
    snd_pkg::rom_byte_t rom_mem [snd_pkg::rom_addr_t];   // bytes placed by the tests
    snd_pkg::rom_addr_t addr_log [$];                    // every address the rom answered
    int                 exp_pcm [$];                     // decoded samples still to be mixed

    sound_board dut (.*);

    always #10 CLK96 = ~CLK96;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic signed [31:0] got,
                               input logic signed [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at time %0t: %s is %0d, expected %0d",
                               $time, what, got, exp));
        end
    endtask

    // unplaced bytes follow a pattern of the whole address
    function automatic snd_pkg::rom_byte_t rom_read(input snd_pkg::rom_addr_t a);
        if (rom_mem.exists(a)) return rom_mem[a];
        return a[7:0] ^ a[15:8] ^ {6'd0, a[17:16]} ^ 8'h5a;
    endfunction

    // signed nibble times 16, clamped to 12-bit signed
    function automatic int decode_ref(input int prev, input logic [3:0] nib);
        int d;
        int next;
        d = nib;
        if (d > 7) d = d - 16;
        next = prev + d * 16;
        if (next > 2047) next = 2047;
        if (next < -2048) next = -2048;
        return next;
    endfunction

    // gains in sixteenths, result saturated to 16 bits
    function automatic int mix_ref(input int fm, input int pcm);
        int fg;
        int pg;
        int s;
        fg = fm_en ? 16 : 0;
        pg = pcm_en ? 16 + 2 * fx_level : 0;
        s  = (fm * fg + pcm * pg) >>> 4;
        if (s > 32767) s = 32767;
        if (s < -32768) s = -32768;
        return s;
    endfunction

    // rom side of the four-phase fetch
    always begin : rom_model
        int delay;
        int n;
        @(posedge CLK96);
        #2;
        if (rst_n && rom_req && !rom_ack) begin
            delay = $random(seed) & 3;                // 0 to 3 extra cycles
            repeat (delay) begin
                @(posedge CLK96);
                #2;
            end
            rom_data = rom_read(rom_addr);
            rom_ack  = 1'b1;
            addr_log.push_back(rom_addr);
            n = 0;
            while (rom_req) begin
                if (n == 20) fail_run("timeout waiting for the voice to drop rom_req");
                @(posedge CLK96);
                #2;
                n++;
            end
            rom_ack = 1'b0;
        end
    end

    task automatic cpu_write(input logic [1:0] a, input logic [7:0] d);
        @(posedge CLK96);
        #2;
        cpu_we   = 1'b1;
        cpu_addr = a;
        cpu_din  = d;
        @(posedge CLK96);
        #2;
        cpu_we = 1'b0;
    endtask

    // queues the expected samples, then programs and starts the voice
    task automatic play(input snd_pkg::rom_addr_t start, input int count);
        int acc;
        snd_pkg::rom_byte_t b;
        acc = 0;
        for (int i = 0; i < count; i++) begin
            b   = rom_read(start + i);
            acc = decode_ref(acc, b[7:4]);            // high nibble first
            exp_pcm.push_back(acc);
            acc = decode_ref(acc, b[3:0]);
            exp_pcm.push_back(acc);
        end
        cpu_write(2'd0, start[7:0]);
        cpu_write(2'd1, start[15:8]);
        cpu_write(2'd2, {6'd0, start[17:16]});
        cpu_write(2'd3, count[7:0]);
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (cpu_busy) begin
            if (n == limit) fail_run("timeout waiting for the voice to finish playing");
            @(posedge CLK96);
            #2;
            n++;
        end
    endtask

    // one fm strobe, checks latency and the mixed value
    task automatic strobe_check(input snd_pkg::audio_t fm, input string what);
        int n;
        int pcm;
        repeat (3) @(posedge CLK96);                  // keeps strobes well apart
        #2;
        fm_in     = fm;
        fm_sample = 1'b1;
        @(posedge CLK96);
        #2;
        fm_sample = 1'b0;
        n = 1;
        while (!mix_valid) begin
            if (n == 12) fail_run("timeout waiting for mix_valid after a sample strobe");
            @(posedge CLK96);
            #2;
            n++;
        end
        pcm = 0;                                      // empty fifo mixes silence
        if (exp_pcm.size() > 0) pcm = exp_pcm.pop_front();
        check_value({what, " latency"}, n, 4);
        check_value({what, " mix_out"}, mix_out, mix_ref(fm, pcm));
    endtask

    task automatic idle_after_reset();
        check_value("mix_valid after reset", mix_valid, 0);
        check_value("peak after reset", peak, 0);
        check_value("rom_req after reset", rom_req, 0);
        check_value("cpu_busy after reset", cpu_busy, 0);
        check_value("mix_out after reset", mix_out, 0);
        strobe_check(16'sd1234, "idle strobe");      // underrun, fm passes through
    endtask

    task automatic play_order();
        rom_mem[18'h00100] = 8'h12;
        rom_mem[18'h00101] = 8'h7f;
        rom_mem[18'h00102] = 8'h88;
        rom_mem[18'h00103] = 8'he3;
        play(18'h00100, 4);
        wait_idle(300);
        for (int i = 0; i < 8; i++) begin
            strobe_check(16'(i * 1000 - 3000), "play order");
        end
        strobe_check(16'sd700, "after last sample");
    endtask

    task automatic stall_on_full();
        addr_log.delete();
        play(18'h240fc, 10);                          // crosses a 256 byte boundary
        repeat (150) @(posedge CLK96);
        #2;
        // 4 bytes fill the fifo, the 5th waits on push_ack
        check_value("rom fetches with fifo full", addr_log.size(), 5);
        check_value("cpu_busy while stalled", cpu_busy, 1);
        for (int i = 0; i < 20; i++) begin
            strobe_check(16'(i * 50), "stall drain");
            // at most 19 of 20 samples pushed after 11 pops
            if (i == 10) check_value("cpu_busy before the last push", cpu_busy, 1);
        end
        wait_idle(100);
        check_value("rom fetch count", addr_log.size(), 10);
        for (int i = 0; i < 10; i++) begin
            check_value("rom address order", addr_log[i], 18'h240fc + i);
        end
        strobe_check(-16'sd200, "stall tail");
    endtask

    task automatic gain_settings();
        rom_mem[18'h00200] = 8'h34;
        rom_mem[18'h00201] = 8'h56;
        rom_mem[18'h00202] = 8'h21;
        play(18'h00200, 3);
        wait_idle(300);
        fm_en = 1'b0;
        strobe_check(16'sd2000, "pcm only");
        fm_en  = 1'b1;
        pcm_en = 1'b0;
        strobe_check(16'sd2000, "fm only");
        pcm_en = 1'b1;
        for (int fx = 0; fx < 4; fx++) begin
            fx_level = 2'(fx);
            strobe_check(-16'sd1500, "fx level");
        end
        fx_level = 2'd0;
    endtask

    task automatic peak_on_saturation();
        rom_mem[18'h00300] = 8'h77;                   // steady climb, +112 per nibble
        rom_mem[18'h00301] = 8'h77;
        play(18'h00300, 2);
        wait_idle(300);
        fx_level = 2'd3;
        strobe_check(16'sh7f00, "near full scale");
        check_value("peak below full scale", peak, 0);
        strobe_check(16'sh7f00, "saturating");
        check_value("saturated mix_out", mix_out, 32767);
        check_value("peak on saturation", peak, 1);
        strobe_check(16'sh7f00, "saturating");
        strobe_check(16'sh7f00, "saturating");
        fx_level = 2'd0;
        strobe_check(16'sd100, "after saturation");
        check_value("peak stays set", peak, 1);
    endtask

    initial begin
        rst_n     = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = 2'd0;
        cpu_din   = 8'd0;
        rom_ack   = 1'b0;
        rom_data  = 8'd0;
        fm_sample = 1'b0;
        fm_in     = '0;
        fm_en     = 1'b1;
        pcm_en    = 1'b1;
        fx_level  = 2'd0;
        repeat (5) @(posedge CLK96);
        #2;
        rst_n = 1'b1;
        idle_after_reset();
        play_order();
        stall_on_full();
        gain_settings();
        peak_on_saturation();
        $display("Test passed");
        $finish;
    end

endmodule

//--- sound_sys.f
hdl/snd_pkg.sv
hdl/pcm_stream_if.sv
hdl/adpcm_voice.sv
hdl/sample_fifo.sv
hdl/sound_mixer.sv
hdl/sound_board.sv
verif/tb_sound_board.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the sound board testbench with verilator, run it, then look for the pass line
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_sound_board \
    -f sound_sys.f -o sim_sound_board > build.log 2>&1 &&
./obj_dir/sim_sound_board > sim.log 2>&1
grep -q "^Test passed$" sim.log && echo "PASS" || { echo "FAIL, see build.log and sim.log"; exit 1; }
